// File: testbench/core_cases.txt
# word stall res flags, all hex; stall 1 lowers cen for 1 to 5 cycles
# flags byte is s z 0 h 0 v n c; registers, rfp and both flag sets start at zero
03FF 0 03FF 00  # ldi r0 3ff
2000 0 07FE 10  # add r0 r0, half carry
7000 0 0000 00  # exf, fresh alternate set
7000 0 0000 10  # exf back
1400 1 07FE 10  # ldr r1 r0, flags kept
2000 0 0FFC 10  # add r0 r0
2000 0 1FF8 10  # add r0 r0
2000 0 3FF0 10  # add r0 r0
2000 0 7FE0 00  # add r0 r0, no half carry
2100 0 87DE 84  # add r0 r1, overflow
3100 1 7FE0 06  # sub r0 r1, overflow
3400 0 881E 83  # sub r1 r0, borrow
2500 0 103C 15  # add r1 r1, carry and overflow
3000 0 0000 42  # sub r0 r0, zero
08FF 0 00FF 42  # ldi r2 0ff
4600 1 003C 14  # and r1 r2, even parity
5600 0 00C3 04  # xor r1 r2
6600 0 FFC4 93  # cp r1 r2
1100 0 00C3 93  # ldr r0 r1, r1 unchanged by cp
8001 0 0000 93  # rfp 1
1D00 1 0000 93  # ldr r3 r1, empty bank
0555 0 0155 93  # ldi r1 155 in bank 1
8000 0 0000 93  # rfp 0
1D00 0 00C3 93  # ldr r3 r1, bank 0 value back

// File: compile.f
rtl/core_pkg.sv
rtl/core_alu.sv
rtl/core_regs.sv
rtl/core_seq.sv
rtl/core_top.sv
testbench/core_chk.sv
testbench/core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module core_tb -f compile.f
out=$(./obj_dir/Vcore_tb 2>&1) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED"

// File: testbench/core_tb.sv
//////////////////////////////
// testbench for the core
// clock, reset, case-file stimulus,
// result checks, timeout, report
//////////////////////////////

`timescale 1ns/1ps

module core_tb import core_pkg::*; ;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        instr_valid;
    logic [15:0] instr;
    logic        instr_ready;
    logic        done;
    logic [15:0] res;
    logic [7:0]  flags;

    logic [15:0] words     [$];
    logic        stalls    [$];
    logic [15:0] exp_res   [$];
    logic [7:0]  exp_flags [$];
    int          errors;
    int          cycles;
    int          limit;

    core_top #(.DATA_W(16)) dut (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .done        (done),
        .res         (res),
        .flags       (flags)
    );

    bind core_top core_chk u_chk (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // limit is zero until the cases are loaded
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: core did not finish the cases within %0d cycles", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, got %h", what, expected, actual);
        end
    endtask

    // lines that do not parse as four hex fields are comments
    task automatic load_cases();
        int              fd;
        int              got;
        int              n;
        logic [8*80-1:0] line;
        logic [15:0]     w;
        logic [3:0]      s;
        logic [15:0]     r;
        logic [7:0]      f;
        fd = $fopen("testbench/core_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file testbench/core_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got != 0) begin
                n = $sscanf(line, "%h %h %h %h", w, s, r, f);
                if (n == 4) begin
                    words.push_back(w);
                    stalls.push_back(s != 4'd0);
                    exp_res.push_back(r);
                    exp_flags.push_back(f);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int    n_stall;
        op_t   op;
        string name;
        void'($urandom(28653));
        rst = 1'b1;
        cen = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        load_cases();
        limit = words.size() * 20 + 100;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        if (words.size() > 0) begin
            instr_valid <= 1'b1;
            instr <= words[0];
        end
        @(negedge clk);
        for (int k = 0; k < words.size(); k++) begin
            op = op_t'(words[k][15:12]);
            name = $sformatf("case %0d %s", k + 1, op.name());
            while (!(instr_ready && cen)) @(negedge clk);
            @(posedge clk);  // acceptance edge
            // next word stays pending while the core is busy
            if (k + 1 < words.size()) begin
                instr <= words[k + 1];
            end else begin
                instr_valid <= 1'b0;
            end
            if (stalls[k]) begin
                @(posedge clk);
                cen <= 1'b0;
                n_stall = $urandom_range(5, 1);
                repeat (n_stall) @(posedge clk);
                cen <= 1'b1;
            end
            @(negedge clk);
            while (!done) begin
                check_value({name, " ready"}, 32'd0, 32'(instr_ready));
                @(negedge clk);
            end
            check_value({name, " res"}, 32'(exp_res[k]), 32'(res));
            check_value({name, " flags"}, 32'(exp_flags[k]), 32'(flags));
        end
        $display("%0d cases run, %0d errors", words.size(), errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/core_chk.sv
//////////////////////////////
// bound assertions on issue
// handshake and done timing
//////////////////////////////

`timescale 1ns/1ps

module core_chk (
    input logic clk,
    input logic rst,
    input logic cen,
    input logic instr_valid,
    input logic instr_ready,
    input logic done
);

    logic accepted;

    assign accepted = instr_valid && instr_ready && cen;

    ready_drops: assert property (@(posedge clk) disable iff (rst)
        accepted |=> !instr_ready)
        else $error("instr_ready still high the cycle after an acceptance");

    // done lasts one enabled cycle
    done_single: assert property (@(posedge clk) disable iff (rst)
        (cen && done) |=> !done)
        else $error("done high on two consecutive enabled cycles");

    // E0 accept, E1 to E4 enabled
    done_not_early: assert property (@(posedge clk) disable iff (rst)
        $past(accepted, 4) && $past(cen, 3) && $past(cen, 2) && $past(cen, 1) && cen
        |-> !done)
        else $error("done came before the fourth enabled edge");

    done_on_time: assert property (@(posedge clk) disable iff (rst)
        $past(accepted, 4) && $past(cen, 3) && $past(cen, 2) && $past(cen, 1) && cen
        |=> done)
        else $error("done missing four enabled edges after acceptance");

    done_reset: assert property (@(posedge clk) $fell(rst) |-> !done)
        else $error("done high right after reset");

endmodule

// File: rtl/core_top.sv
//////////////////////////////
// core top level
// sequencer, registers, ALU
//////////////////////////////

`timescale 1ns/1ps

module core_top import core_pkg::*; #(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              instr_valid,
    input  logic [15:0]       instr,
    output logic              instr_ready,
    output logic              done,
    output logic [DATA_W-1:0] res,
    output logic [7:0]        flags
);

    instr_t            md;
    op_t               op;
    ral_t              ral_sel;
    rmux_t             rmux_sel;
    opnd_t             opnd_sel;
    cc_t               cc_sel;
    ld_t               ld_sel;
    logic [DATA_W-1:0] op0, op1, rslt;
    logic              zi, hi, vi, ni, ci, pi;

    core_seq u_seq (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .done        (done),
        .md          (md),
        .op          (op),
        .ral_sel     (ral_sel),
        .rmux_sel    (rmux_sel),
        .opnd_sel    (opnd_sel),
        .cc_sel      (cc_sel),
        .ld_sel      (ld_sel)
    );

    core_regs #(.DATA_W(DATA_W)) u_regs (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .md       (md),
        .ral_sel  (ral_sel),
        .rmux_sel (rmux_sel),
        .opnd_sel (opnd_sel),
        .cc_sel   (cc_sel),
        .ld_sel   (ld_sel),
        .rslt     (rslt),
        .zi       (zi),
        .hi       (hi),
        .vi       (vi),
        .ni       (ni),
        .ci       (ci),
        .pi       (pi),
        .op0      (op0),
        .op1      (op1),
        .op2      (res),  // result latched at write-back
        .flags    (flags)
    );

    core_alu #(.DATA_W(DATA_W)) u_alu (
        .op   (op),
        .op0  (op0),
        .op1  (op1),
        .rslt (rslt),
        .zi   (zi),
        .hi   (hi),
        .vi   (vi),
        .ni   (ni),
        .ci   (ci),
        .pi   (pi)
    );

endmodule

// File: rtl/core_seq.sv
//////////////////////////////
// instruction sequencer
// issue handshake, four steps
// of register-file control codes
//////////////////////////////

`timescale 1ns/1ps

module core_seq import core_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   cen,
    input  logic   instr_valid,
    input  instr_t instr,
    output logic   instr_ready,
    output logic   done,
    output instr_t md,
    output op_t    op,
    output ral_t   ral_sel,
    output rmux_t  rmux_sel,
    output opnd_t  opnd_sel,
    output cc_t    cc_sel,
    output ld_t    ld_sel
);

    localparam logic [2:0] IDLE = 3'd0;
    localparam logic [2:0] S1   = 3'd1;
    localparam logic [2:0] S2   = 3'd2;
    localparam logic [2:0] S3   = 3'd3;
    localparam logic [2:0] S4   = 3'd4;

    logic [2:0] step;
    logic       accept;

    assign instr_ready = (step == IDLE);
    assign accept      = instr_valid && instr_ready;
    assign op          = md.r.opcode;

    always_ff @(posedge clk) begin
        if (cen && accept) md <= instr;  // held until the next issue
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            step <= IDLE;
            done <= 1'b0;
        end else if (cen) begin
            done <= (step == S4);
            case (step)
                IDLE:    step <= accept ? S1 : IDLE;
                S4:      step <= IDLE;
                default: step <= step + 3'd1;
            endcase
        end
    end

    // one control word per step
    always_comb begin
        ral_sel  = NONE_RAL;
        rmux_sel = ZERO_RMUX;
        opnd_sel = NONE_OPND;
        cc_sel   = NONE_CC;
        ld_sel   = NONE_LD;
        case (step)
            S1: ral_sel = LATCH_RAL;
            S2: begin
                rmux_sel = DST_RMUX;
                opnd_sel = LD0_OPND;
            end
            S3: begin
                opnd_sel = LD1_OPND;
                case (op)
                    LDI, RFP: rmux_sel = IMM_RMUX;
                    EXF:      rmux_sel = ZERO_RMUX;  // res reads zero
                    default:  rmux_sel = SRC_RMUX;
                endcase
            end
            S4: begin
                case (op)
                    LDI, LDR: ld_sel = DST_LD;  // flags untouched
                    ADD: begin
                        ld_sel = DST_LD;
                        cc_sel = ARITH_N0_CC;
                    end
                    SUB: begin
                        ld_sel = DST_LD;
                        cc_sel = ARITH_N1_CC;
                    end
                    AND: begin
                        ld_sel = DST_LD;
                        cc_sel = LOGIC_H1_CC;
                    end
                    XOR: begin
                        ld_sel = DST_LD;
                        cc_sel = LOGIC_H0_CC;
                    end
                    CP:      cc_sel = ARITH_N1_CC;  // compare, no write
                    EXF:     cc_sel = EXF_CC;
                    RFP:     ld_sel = RFP_LD;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/core_regs.sv
//////////////////////////////
// banked register file
// address latches, operand mux,
// operand latches, write-back,
// main and alternate flag sets
//////////////////////////////

`timescale 1ns/1ps

module core_regs import core_pkg::*; #(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  instr_t            md,
    input  ral_t              ral_sel,
    input  rmux_t             rmux_sel,
    input  opnd_t             opnd_sel,
    input  cc_t               cc_sel,
    input  ld_t               ld_sel,
    input  logic [DATA_W-1:0] rslt,
    input  logic              zi,
    input  logic              hi,
    input  logic              vi,
    input  logic              ni,
    input  logic              ci,
    input  logic              pi,
    output logic [DATA_W-1:0] op0,
    output logic [DATA_W-1:0] op1,
    output logic [DATA_W-1:0] op2,
    output logic [7:0]        flags
);

    logic [DATA_W-1:0] regs [0:15];  // four banks of four
    logic [DATA_W-1:0] rmux;
    logic [3:0]        src, dst;     // {rfp, field}
    logic [1:0]        rfp;
    logic              s, z, h, v, n, c;
    logic              s_, z_, h_, v_, n_, c_;  // alternate set
    logic              wb;

    assign flags = {s, z, 1'b0, h, 1'b0, v, n, c};

    // every final step either writes or touches flags
    assign wb = (ld_sel != NONE_LD) || (cc_sel != NONE_CC);

    always_comb begin
        case (rmux_sel)
            DST_RMUX: rmux = regs[dst];
            SRC_RMUX: rmux = regs[src];
            IMM_RMUX: rmux = DATA_W'(md.i.imm);  // zero extended
            default:  rmux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            case (opnd_sel)
                LD0_OPND: op0 <= rmux;
                LD1_OPND: op1 <= rmux;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
            src <= '0;
            dst <= '0;
            rfp <= '0;
            op2 <= '0;
            {s, z, h, v, n, c} <= '0;
            {s_, z_, h_, v_, n_, c_} <= '0;
        end else if (cen) begin
            if (ral_sel == LATCH_RAL) begin
                src <= {rfp, md.r.src};
                dst <= {rfp, md.r.dst};
            end
            case (ld_sel)
                DST_LD: regs[dst] <= rslt;
                RFP_LD: rfp <= rslt[1:0];
                default: ;
            endcase
            if (wb) begin
                op2 <= (ld_sel == RFP_LD) ? '0 : rslt;  // pointer load reports zero
            end
            case (cc_sel)
                ARITH_N0_CC: {s, z, h, v, n, c} <= {ni, zi, hi, vi, 1'b0, ci};
                ARITH_N1_CC: {s, z, h, v, n, c} <= {ni, zi, hi, vi, 1'b1, ci};
                LOGIC_H1_CC: {s, z, h, v, n, c} <= {ni, zi, 1'b1, pi, 1'b0, 1'b0};
                LOGIC_H0_CC: {s, z, h, v, n, c} <= {ni, zi, 1'b0, pi, 1'b0, 1'b0};
                EXF_CC: begin
                    {s, z, h, v, n, c}       <= {s_, z_, h_, v_, n_, c_};
                    {s_, z_, h_, v_, n_, c_} <= {s, z, h, v, n, c};
                end
                default: ;
            endcase
        end
    end

endmodule

// File: rtl/core_alu.sv
//////////////////////////////
// combinational ALU
// result and candidate flags
//////////////////////////////

`timescale 1ns/1ps

module core_alu import core_pkg::*; #(
    parameter int DATA_W = 16
) (
    input  op_t               op,
    input  logic [DATA_W-1:0] op0,
    input  logic [DATA_W-1:0] op1,
    output logic [DATA_W-1:0] rslt,
    output logic              zi,
    output logic              hi,
    output logic              vi,
    output logic              ni,
    output logic              ci,
    output logic              pi
);

    localparam int MSB = DATA_W - 1;

    logic [DATA_W:0] sum, diff;
    logic [4:0]      hsum, hdiff;  // low nibble only, for half carry

    assign sum   = {1'b0, op0} + {1'b0, op1};
    assign diff  = {1'b0, op0} - {1'b0, op1};
    assign hsum  = {1'b0, op0[3:0]} + {1'b0, op1[3:0]};
    assign hdiff = {1'b0, op0[3:0]} - {1'b0, op1[3:0]};

    always_comb begin
        rslt = op1;  // loads pass the second operand
        hi   = 1'b0;
        vi   = 1'b0;
        ci   = 1'b0;
        case (op)
            ADD: begin
                rslt = sum[MSB:0];
                hi   = hsum[4];
                ci   = sum[DATA_W];
                vi   = (op0[MSB] == op1[MSB]) && (sum[MSB] != op0[MSB]);
            end
            SUB, CP: begin
                rslt = diff[MSB:0];
                hi   = hdiff[4];    // borrow out of bit 3
                ci   = diff[DATA_W];
                vi   = (op0[MSB] != op1[MSB]) && (diff[MSB] != op0[MSB]);
            end
            AND: rslt = op0 & op1;
            XOR: rslt = op0 ^ op1;
            default: ;
        endcase
    end

    assign zi = (rslt == '0);
    assign ni = rslt[MSB];      // feeds the s flag
    assign pi = ~^rslt[7:0];    // even parity of low byte

endmodule

// File: rtl/core_pkg.sv
//////////////////////////////
// shared types for the core
// opcodes, control-step codes,
// instruction union, flag byte
//////////////////////////////

package core_pkg;

    typedef enum logic [3:0] {
        LDI = 4'd0,
        LDR = 4'd1,
        ADD = 4'd2,
        SUB = 4'd3,
        AND = 4'd4,
        XOR = 4'd5,
        CP  = 4'd6,
        EXF = 4'd7,
        RFP = 4'd8
    } op_t;

    // register form: dst op src
    typedef struct packed {
        op_t        opcode;
        logic [1:0] dst;
        logic [1:0] src;
        logic [7:0] rsvd;
    } instr_reg_t;

    // immediate form: dst op #imm
    typedef struct packed {
        op_t        opcode;
        logic [1:0] dst;
        logic [9:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    typedef enum logic [1:0] {NONE_RAL, LATCH_RAL} ral_t;

    typedef enum logic [1:0] {DST_RMUX, SRC_RMUX, IMM_RMUX, ZERO_RMUX} rmux_t;

    typedef enum logic [1:0] {NONE_OPND, LD0_OPND, LD1_OPND} opnd_t;

    typedef enum logic [2:0] {
        NONE_CC,
        ARITH_N0_CC,  // s z h v c from alu, n=0
        ARITH_N1_CC,  // same, n=1
        LOGIC_H1_CC,  // s z from alu, h=1, v=parity, n=0, c=0
        LOGIC_H0_CC,  // as above with h=0
        EXF_CC        // swap main and alternate sets
    } cc_t;

    typedef enum logic [1:0] {NONE_LD, DST_LD, RFP_LD} ld_t;

    // flag byte, bit 7 down: s z 0 h 0 v n c

endpackage
